// File: x86_decode_pkg.sv
`default_nettype none

package x86_decode_pkg;

   // operand size as carried toward address generation
   typedef enum logic [1:0] {
      sz_byte  = 2'b00,
      sz_word  = 2'b01,
      sz_dword = 2'b10,
      sz_qword = 2'b11
   } size_e;

   // segment register ids, same numbering as the sreg field
   typedef enum logic [2:0] {
      es = 3'd0,
      cs = 3'd1,
      ss = 3'd2,
      ds = 3'd3,
      fs = 3'd4,
      gs = 3'd5
   } seg_e;

   // follows the group 1 reg field, so modrm[5:3] maps straight onto it
   typedef enum logic [2:0] {
      alu_add  = 3'd0,
      alu_or   = 3'd1,
      alu_pass = 3'd2,
      alu_and  = 3'd4,
      alu_sub  = 3'd5,
      alu_xor  = 3'd6,
      alu_cmp  = 3'd7
   } alu_op_e;

   typedef enum logic [3:0] {
      op_add_rm_r,
      op_mov_r_rm,
      op_mov_rm_imm,
      op_push_es,
      op_cmpxchg,
      op_illegal
   } op_e;

   localparam int uaddr_w = 8;

   // control store entry points
   localparam logic [uaddr_w-1:0] ua_add      = 8'h01;
   localparam logic [uaddr_w-1:0] ua_mov_ld   = 8'h02;
   localparam logic [uaddr_w-1:0] ua_mov_imm  = 8'h03;
   localparam logic [uaddr_w-1:0] ua_push_es  = 8'h04;
   localparam logic [uaddr_w-1:0] ua_cmpxchg0 = 8'h10;
   localparam logic [uaddr_w-1:0] ua_cmpxchg1 = 8'h11;
   localparam logic [uaddr_w-1:0] ua_illegal  = 8'hff;

   // opcode bytes
   localparam logic [7:0] opc_add_rm_r   = 8'h01;
   localparam logic [7:0] opc_mov_r_rm   = 8'h8b;
   localparam logic [7:0] opc_mov_rm_imm = 8'hc7;
   localparam logic [7:0] opc_push_es    = 8'h06;
   localparam logic [7:0] opc_escape     = 8'h0f;
   localparam logic [7:0] opc_cmpxchg    = 8'hb1;

   // prefix bytes
   localparam logic [7:0] pfx_opsize = 8'h66;
   localparam logic [7:0] pfx_es     = 8'h26;
   localparam logic [7:0] pfx_cs     = 8'h2e;
   localparam logic [7:0] pfx_ss     = 8'h36;
   localparam logic [7:0] pfx_ds     = 8'h3e;
   localparam logic [7:0] pfx_fs     = 8'h64;
   localparam logic [7:0] pfx_gs     = 8'h65;

endpackage

`default_nettype wire

// File: instr_field_extract.sv
`timescale 1ns/1ps
`default_nettype none

module instr_field_extract (
   input  wire  [127:0]               ir,
   input  wire                        in_valid,
   output x86_decode_pkg::op_e        opcode,
   output logic                       operand_override,
   output logic                       seg_override_present,
   output x86_decode_pkg::seg_e       seg_override_id,
   output logic                       modrm_present,
   output logic [7:0]                 modrm,
   output logic                       sib_present,
   output logic [7:0]                 sib,
   output logic [31:0]                disp32,
   output logic [31:0]                imm32,
   output logic [3:0]                 instr_len
);
   import x86_decode_pkg::*;

   logic [7:0]  b0, b1, op_byte, op_byte2, d8;
   logic        pfx0, pfx1, escape, has_modrm, has_sib, opsz, segp;
   logic [3:0]  npfx, modrm_pos, disp_pos, imm_pos, disp_len, imm_len;
   logic [31:0] imm_raw;

   function automatic logic [7:0] byte_at(input logic [127:0] w, input logic [3:0] idx);
      return w[{idx, 3'b000} +: 8];
   endfunction

   // little endian dword starting at byte idx
   function automatic logic [31:0] dword_at(input logic [127:0] w, input logic [3:0] idx);
      return {byte_at(w, idx + 4'd3), byte_at(w, idx + 4'd2),
              byte_at(w, idx + 4'd1), byte_at(w, idx)};
   endfunction

   function automatic logic is_seg_pfx(input logic [7:0] b);
      return b inside {pfx_es, pfx_cs, pfx_ss, pfx_ds, pfx_fs, pfx_gs};
   endfunction

   function automatic seg_e seg_of(input logic [7:0] b);
      case (b)
         pfx_es:  return es;
         pfx_cs:  return cs;
         pfx_ss:  return ss;
         pfx_fs:  return fs;
         pfx_gs:  return gs;
         default: return ds;
      endcase
   endfunction

   always_comb begin
      // up to two prefix bytes ahead of the opcode
      b0   = byte_at(ir, 4'd0);
      b1   = byte_at(ir, 4'd1);
      pfx0 = (b0 == pfx_opsize) || is_seg_pfx(b0);
      pfx1 = pfx0 && ((b1 == pfx_opsize) || is_seg_pfx(b1));
      npfx = 4'(pfx0) + 4'(pfx1);
      opsz = (b0 == pfx_opsize) || (pfx1 && b1 == pfx_opsize);
      segp = is_seg_pfx(b0) || (pfx1 && is_seg_pfx(b1));
      seg_override_id = (pfx1 && is_seg_pfx(b1)) ? seg_of(b1) : seg_of(b0);

      op_byte   = byte_at(ir, npfx);
      op_byte2  = byte_at(ir, npfx + 4'd1);
      escape    = (op_byte == opc_escape);
      modrm_pos = npfx + (escape ? 4'd2 : 4'd1);
      modrm     = byte_at(ir, modrm_pos);
      sib       = byte_at(ir, modrm_pos + 4'd1);

      opcode    = op_illegal;
      has_modrm = 1'b0;
      imm_len   = 4'd0;
      if (escape) begin
         if (op_byte2 == opc_cmpxchg) begin
            opcode    = op_cmpxchg;
            has_modrm = 1'b1;
         end
      end else begin
         case (op_byte)
            opc_add_rm_r: begin
               opcode    = op_add_rm_r;
               has_modrm = 1'b1;
            end
            opc_mov_r_rm: begin
               opcode    = op_mov_r_rm;
               has_modrm = 1'b1;
            end
            opc_mov_rm_imm: begin
               // only the /0 form is defined
               if (modrm[5:3] == 3'b000) begin
                  opcode    = op_mov_rm_imm;
                  has_modrm = 1'b1;
                  imm_len   = opsz ? 4'd2 : 4'd4;
               end
            end
            opc_push_es: opcode = op_push_es;
            default: ;
         endcase
      end

      // sib and displacement from mod and rm
      has_sib = has_modrm && (modrm[7:6] != 2'b11) && (modrm[2:0] == 3'b100);
      case (modrm[7:6])
         2'b01:   disp_len = 4'd1;
         2'b10:   disp_len = 4'd4;
         2'b00:   disp_len = (modrm[2:0] == 3'b101 || (has_sib && sib[2:0] == 3'b101))
                             ? 4'd4 : 4'd0;
         default: disp_len = 4'd0;
      endcase
      if (!has_modrm)
         disp_len = 4'd0;

      disp_pos = modrm_pos + 4'd1 + 4'(has_sib);
      imm_pos  = has_modrm ? disp_pos + disp_len : modrm_pos;
      d8       = byte_at(ir, disp_pos);
      imm_raw  = dword_at(ir, imm_pos);

      if (disp_len == 4'd4)
         disp32 = dword_at(ir, disp_pos);
      else if (disp_len == 4'd1)
         disp32 = {{24{d8[7]}}, d8};
      else
         disp32 = 32'd0;

      // imm16 under 0x66 is zero extended
      if (imm_len == 4'd4)
         imm32 = imm_raw;
      else if (imm_len == 4'd2)
         imm32 = {16'h0000, imm_raw[15:0]};
      else
         imm32 = 32'd0;

      operand_override     = in_valid && opsz;
      seg_override_present = in_valid && segp;
      modrm_present        = in_valid && has_modrm;
      sib_present          = in_valid && has_sib;
      instr_len = in_valid ? modrm_pos + 4'(has_modrm) + 4'(has_sib) + disp_len + imm_len
                           : 4'd0;
   end

endmodule

`default_nettype wire

// File: ucode_rom.sv
`timescale 1ns/1ps
`default_nettype none

module ucode_rom (
   input  wire  [x86_decode_pkg::uaddr_w-1:0] uaddr,
   output x86_decode_pkg::alu_op_e            alu_op,
   output logic                               src_from_reg, mem_rd_cs, mem_wr_cs,
   output logic                               ld_gpr_cs, seg_needed_cs, uop_more,
   output logic [x86_decode_pkg::uaddr_w-1:0] next_uaddr,
   output logic                               gp_exc
);
   import x86_decode_pkg::*;

   always_comb begin
      // fields an entry does not name stay inactive
      alu_op        = alu_pass;
      src_from_reg  = 1'b0;
      mem_rd_cs     = 1'b0;
      mem_wr_cs     = 1'b0;
      ld_gpr_cs     = 1'b0;
      seg_needed_cs = 1'b0;
      uop_more      = 1'b0;
      next_uaddr    = '0;
      gp_exc        = 1'b0;
      case (uaddr)
         ua_add: begin
            alu_op    = alu_add;
            ld_gpr_cs = 1'b1;
         end
         ua_mov_ld:  ld_gpr_cs = 1'b1;
         ua_mov_imm: ld_gpr_cs = 1'b1;
         ua_push_es: begin
            // es is the source, the stack slot is written and esp updated
            mem_wr_cs     = 1'b1;
            ld_gpr_cs     = 1'b1;
            seg_needed_cs = 1'b1;
         end
         ua_cmpxchg0: begin
            // compare eax against the destination first
            alu_op     = alu_cmp;
            uop_more   = 1'b1;
            next_uaddr = ua_cmpxchg1;
         end
         ua_cmpxchg1: ld_gpr_cs = 1'b1;
         default:     gp_exc = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

// File: decode_stage2.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage2 (
   input  wire                                clk, reset,
   input  wire                                in_valid, ag_stall, flush,
   input  wire  x86_decode_pkg::op_e          opcode,
   input  wire                                operand_override, seg_override_present,
   input  wire  x86_decode_pkg::seg_e         seg_override_id,
   input  wire                                modrm_present, sib_present,
   input  wire  [7:0]                         modrm, sib,
   input  wire  [31:0]                        fx_disp32, fx_imm32, eip,
   input  wire  [3:0]                         instr_len,
   input  wire  x86_decode_pkg::alu_op_e      cs_alu_op,
   input  wire                                src_from_reg, mem_rd_cs, mem_wr_cs,
   input  wire                                ld_gpr_cs, seg_needed_cs, uop_more,
   input  wire  [x86_decode_pkg::uaddr_w-1:0] next_uaddr,
   input  wire                                cs_gp_exc,
   output logic [x86_decode_pkg::uaddr_w-1:0] uaddr,
   output x86_decode_pkg::alu_op_e            alu_op,
   output logic [2:0]                         sr1, sr2,
   output x86_decode_pkg::seg_e               seg1,
   output x86_decode_pkg::size_e              sr1_size, mem_size,
   output logic                               mem_rd, mem_wr, ld_gpr,
   output logic [31:0]                        disp32, imm32, eip_next,
   output logic                               gp_exc, uop_stall
);
   import x86_decode_pkg::*;

   logic               sel_uop;
   logic [uaddr_w-1:0] saved_uaddr;
   logic [uaddr_w-1:0] entry_uaddr;
   logic               mod_mem, ss_default;
   size_e              op_size;

   always_comb begin
      case (opcode)
         op_add_rm_r:   entry_uaddr = ua_add;
         op_mov_r_rm:   entry_uaddr = ua_mov_ld;
         op_mov_rm_imm: entry_uaddr = ua_mov_imm;
         op_push_es:    entry_uaddr = ua_push_es;
         op_cmpxchg:    entry_uaddr = ua_cmpxchg0;
         default:       entry_uaddr = ua_illegal;
      endcase
   end

   // later micro-ops of a sequence come from the saved next address
   assign uaddr     = sel_uop ? saved_uaddr : entry_uaddr;
   assign uop_stall = in_valid && uop_more && !flush;

   always_ff @(posedge clk) begin
      if (reset || flush)
         sel_uop <= 1'b0;
      else if (!ag_stall)
         sel_uop <= uop_stall;
   end

   always_ff @(posedge clk) begin
      if (in_valid && !ag_stall)
         saved_uaddr <= next_uaddr;
   end

   assign mod_mem = modrm_present && (modrm[7:6] != 2'b11);
   assign op_size = operand_override ? sz_word : sz_dword;

   // a base register used for addressing is always 32 bit
   assign sr1_size = mod_mem ? sz_dword : op_size;
   assign mem_size = op_size;
   assign sr1      = sib_present ? sib[2:0] : modrm[2:0];
   assign sr2      = modrm[5:3];
   assign alu_op   = src_from_reg ? alu_op_e'(modrm[5:3]) : cs_alu_op;

   // ebp based or esp based addressing defaults to the stack segment
   assign ss_default = (modrm_present && (modrm[7] ^ modrm[6]) && modrm[2:0] == 3'b101)
                    || (sib_present && sib[2:0] == 3'b100);

   always_comb begin
      if (seg_override_present)
         seg1 = seg_override_id;
      else if (seg_needed_cs)
         seg1 = es;
      else if (ss_default)
         seg1 = ss;
      else
         seg1 = ds;
   end

   always_comb begin
      mem_rd = mem_rd_cs;
      mem_wr = mem_wr_cs;
      if (modrm_present) begin
         mem_rd = mod_mem;
         mem_wr = mod_mem && (opcode != op_mov_r_rm);
      end
   end

   // memory destination, so no register write back
   assign ld_gpr = ld_gpr_cs && !(mod_mem && (opcode inside {op_add_rm_r, op_mov_rm_imm}));

   assign eip_next = uop_more ? eip : eip + {28'd0, instr_len};
   assign disp32   = fx_disp32;
   assign imm32    = fx_imm32;
   assign gp_exc   = cs_gp_exc;

endmodule

`default_nettype wire

// File: d2_ag_latch.sv
`timescale 1ns/1ps
`default_nettype none

module d2_ag_latch (
   input  wire                                clk, reset, ag_stall, flush, v,
   input  wire  [x86_decode_pkg::uaddr_w-1:0] uaddr,
   input  wire  x86_decode_pkg::alu_op_e      alu_op,
   input  wire  [2:0]                         sr1, sr2,
   input  wire  x86_decode_pkg::seg_e         seg1,
   input  wire  x86_decode_pkg::size_e        sr1_size, mem_size,
   input  wire                                mem_rd, mem_wr, ld_gpr, gp_exc,
   input  wire  [31:0]                        disp32, imm32, eip_next,
   output logic                               ag_valid,
   output logic [x86_decode_pkg::uaddr_w-1:0] ag_uaddr,
   output x86_decode_pkg::alu_op_e            ag_alu_op,
   output logic [2:0]                         ag_sr1, ag_sr2,
   output x86_decode_pkg::seg_e               ag_seg1,
   output x86_decode_pkg::size_e              ag_sr1_size, ag_mem_size,
   output logic                               ag_mem_rd, ag_mem_wr, ag_ld_gpr, ag_gp_exc,
   output logic [31:0]                        ag_disp32, ag_imm32, ag_eip_next
);

   always_ff @(posedge clk) begin
      if (reset) begin
         ag_valid  <= 1'b0;
         ag_mem_rd <= 1'b0;
         ag_mem_wr <= 1'b0;
         ag_ld_gpr <= 1'b0;
         ag_gp_exc <= 1'b0;
      end else begin
         if (flush)
            ag_valid <= 1'b0;
         else if (!ag_stall)
            ag_valid <= v;
         if (!ag_stall) begin
            ag_mem_rd <= mem_rd;
            ag_mem_wr <= mem_wr;
            ag_ld_gpr <= ld_gpr;
            ag_gp_exc <= gp_exc;
         end
      end
   end

   // operand fields, held while address generation is stalled
   always_ff @(posedge clk) begin
      if (!ag_stall) begin
         ag_uaddr    <= uaddr;
         ag_alu_op   <= alu_op;
         ag_sr1      <= sr1;
         ag_sr2      <= sr2;
         ag_seg1     <= seg1;
         ag_sr1_size <= sr1_size;
         ag_mem_size <= mem_size;
         ag_disp32   <= disp32;
         ag_imm32    <= imm32;
         ag_eip_next <= eip_next;
      end
   end

endmodule

`default_nettype wire

// File: decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_top (
   input  wire                                clk, reset,
   input  wire                                in_valid, ag_stall, flush,
   input  wire  [127:0]                       ir,
   input  wire  [31:0]                        eip,
   output logic                               ag_valid,
   output logic [x86_decode_pkg::uaddr_w-1:0] ag_uaddr,
   output x86_decode_pkg::alu_op_e            ag_alu_op,
   output logic [2:0]                         ag_sr1, ag_sr2,
   output x86_decode_pkg::seg_e               ag_seg1,
   output x86_decode_pkg::size_e              ag_sr1_size, ag_mem_size,
   output logic                               ag_mem_rd, ag_mem_wr, ag_ld_gpr, ag_gp_exc,
   output logic [31:0]                        ag_disp32, ag_imm32, ag_eip_next,
   output logic                               uop_stall
);
   import x86_decode_pkg::*;

   // extractor fields
   op_e                opcode;
   seg_e               seg_override_id;
   logic               operand_override, seg_override_present, modrm_present, sib_present;
   logic [7:0]         modrm, sib;
   logic [31:0]        fx_disp32, fx_imm32;
   logic [3:0]         instr_len;

   // control store word
   alu_op_e            cs_alu_op;
   logic               src_from_reg, mem_rd_cs, mem_wr_cs, ld_gpr_cs;
   logic               seg_needed_cs, uop_more, cs_gp_exc;
   logic [uaddr_w-1:0] uaddr, next_uaddr;

   // stage 2 results toward the latch
   alu_op_e            alu_op;
   seg_e               seg1;
   size_e              sr1_size, mem_size;
   logic [2:0]         sr1, sr2;
   logic               mem_rd, mem_wr, ld_gpr, gp_exc;
   logic [31:0]        disp32, imm32, eip_next;

   instr_field_extract u_extract (
      .ir, .in_valid, .opcode, .operand_override, .seg_override_present, .seg_override_id,
      .modrm_present, .modrm, .sib_present, .sib, .disp32(fx_disp32), .imm32(fx_imm32),
      .instr_len
   );

   ucode_rom u_rom (
      .uaddr, .alu_op(cs_alu_op), .src_from_reg, .mem_rd_cs, .mem_wr_cs, .ld_gpr_cs,
      .seg_needed_cs, .uop_more, .next_uaddr, .gp_exc(cs_gp_exc)
   );

   decode_stage2 u_stage2 (
      .clk, .reset, .in_valid, .ag_stall, .flush, .opcode, .operand_override,
      .seg_override_present, .seg_override_id, .modrm_present, .sib_present, .modrm, .sib,
      .fx_disp32, .fx_imm32, .eip, .instr_len, .cs_alu_op, .src_from_reg, .mem_rd_cs,
      .mem_wr_cs, .ld_gpr_cs, .seg_needed_cs, .uop_more, .next_uaddr, .cs_gp_exc,
      .uaddr, .alu_op, .sr1, .sr2, .seg1, .sr1_size, .mem_size, .mem_rd, .mem_wr, .ld_gpr,
      .disp32, .imm32, .eip_next, .gp_exc, .uop_stall
   );

   d2_ag_latch u_latch (
      .clk, .reset, .ag_stall, .flush, .v(in_valid), .uaddr, .alu_op, .sr1, .sr2, .seg1,
      .sr1_size, .mem_size, .mem_rd, .mem_wr, .ld_gpr, .gp_exc, .disp32, .imm32, .eip_next,
      .ag_valid, .ag_uaddr, .ag_alu_op, .ag_sr1, .ag_sr2, .ag_seg1, .ag_sr1_size,
      .ag_mem_size, .ag_mem_rd, .ag_mem_wr, .ag_ld_gpr, .ag_gp_exc, .ag_disp32, .ag_imm32,
      .ag_eip_next
   );

endmodule

`default_nettype wire

// File: decode_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module decode_assertions (
   input wire                                clk, reset, flush, ag_stall, ag_valid,
   input wire [x86_decode_pkg::uaddr_w-1:0] ag_uaddr,
   input wire [31:0]                        ag_eip_next, ag_disp32,
   input wire                                sel_uop, uop_stall
);

   int fail_count = 0;

   a_valid_cleared: assert property (@(posedge clk) (reset || flush) |=> !ag_valid)
      else begin
         $error("ag_valid set in the cycle after reset or flush");
         fail_count++;
      end

   // a stalled latch keeps its contents
   a_stall_hold: assert property (@(posedge clk) (ag_stall && !reset && !flush) |=>
      ($stable(ag_valid) && $stable(ag_uaddr) && $stable(ag_eip_next) && $stable(ag_disp32)))
      else begin
         $error("latch outputs changed while ag_stall was high");
         fail_count++;
      end

   // the sequenced micro-op is the last one of its instruction
   a_last_uop: assert property (@(posedge clk) disable iff (reset) sel_uop |-> !uop_stall)
      else begin
         $error("uop_stall raised on the last micro-op");
         fail_count++;
      end

endmodule

bind decode_top decode_assertions u_assertions (
   .clk, .reset, .flush, .ag_stall, .ag_valid, .ag_uaddr, .ag_eip_next, .ag_disp32,
   .sel_uop(u_stage2.sel_uop), .uop_stall
);

`default_nettype wire

// File: tb_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode;
   import x86_decode_pkg::*;

   localparam int reset_cycles = 4;
   localparam int num_tests    = 6;
   // budget per test is several times what the longest test takes
   localparam int test_budget  = 66;
   localparam int max_cycles   = reset_cycles + num_tests * test_budget;

   logic               clk = 1'b0;
   logic               reset, in_valid, ag_stall, flush;
   logic [127:0]       ir;
   logic [31:0]        eip;
   logic               ag_valid, ag_mem_rd, ag_mem_wr, ag_ld_gpr, ag_gp_exc, uop_stall;
   logic [uaddr_w-1:0] ag_uaddr;
   alu_op_e            ag_alu_op;
   logic [2:0]         ag_sr1, ag_sr2;
   seg_e               ag_seg1;
   size_e              ag_sr1_size, ag_mem_size;
   logic [31:0]        ag_disp32, ag_imm32, ag_eip_next;

   int                 errors = 0;
   int                 checks = 0;
   int                 cycle_count = 0;
   logic [15:0]        lfsr_state = 16'd36698;
   logic [7:0]         win_bytes [16];
   int                 win_len;

   decode_top dut (.*);

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == max_cycles) begin
         $display("timeout: the run did not finish within %0d cycles", max_cycles);
         $display("Errors found");
         $finish;
      end
   end

   // taps 16 14 13 11 with the new bit entering at the top
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   task automatic clear_window;
      // filler after the instruction follows the byte index
      for (int i = 0; i < 16; i++)
         win_bytes[i] = {4'hc, 4'(i)};
      win_len = 0;
   endtask

   // appends n bytes of v, low byte first
   task automatic put_bytes(input logic [31:0] v, input int n);
      for (int k = 0; k < n; k++) begin
         win_bytes[win_len] = v[8*k +: 8];
         win_len++;
      end
   endtask

   function automatic logic [127:0] window_bits();
      logic [127:0] w;
      for (int i = 0; i < 16; i++)
         w[8*i +: 8] = win_bytes[i];
      return w;
   endfunction

   task automatic check_u32(input string what, input logic [31:0] got, exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_u8(input string what, input logic [7:0] got, exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_seg(input string what, input seg_e got, exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: %s is %b, expected %s", $time, what, got, exp.name());
      end
   endtask

   task automatic check_size(input string what, input size_e got, exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: %s is %b, expected %s", $time, what, got, exp.name());
      end
   endtask

   task automatic check_alu(input string what, input alu_op_e got, exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: %s is %b, expected %s", $time, what, got, exp.name());
      end
   endtask

   task automatic drive_window(input logic [31:0] e);
      @(posedge clk);
      in_valid <= 1'b1;
      ir       <= window_bits();
      eip      <= e;
   endtask

   task automatic wait_valid;
      @(negedge clk);
      while (ag_valid !== 1'b1)
         @(negedge clk);
   endtask

   // a single micro-op needs in_valid for one cycle only
   task automatic issue_single(input logic [31:0] e);
      drive_window(e);
      @(negedge clk);
      check_u8("uop_stall", uop_stall, 8'd0);
      @(posedge clk);
      in_valid <= 1'b0;
      wait_valid();
   endtask

   task automatic end_test(input string name, input int start);
      $display("test %s finished with %0d mismatches", name, errors - start);
   endtask

   task automatic test_mem_operands;
      int          start;
      logic [7:0]  d8;
      logic [31:0] d32;
      logic [31:0] e;
      start = errors;
      // mov ecx,[ebp+disp8] with a negative disp8
      d8 = {1'b1, 7'(random_bits(7))};
      e  = 32'h0040_1000;
      clear_window();
      put_bytes(32'h8b, 1);
      put_bytes(32'h4d, 1);
      put_bytes({24'd0, d8}, 1);
      issue_single(e);
      check_u8("mov uaddr", ag_uaddr, ua_mov_ld);
      check_seg("mov seg1", ag_seg1, ss);
      check_u8("mov sr1", ag_sr1, 8'd5);
      check_u8("mov sr2", ag_sr2, 8'd1);
      check_u8("mov mem_rd", ag_mem_rd, 8'd1);
      check_u8("mov mem_wr", ag_mem_wr, 8'd0);
      check_u8("mov ld_gpr", ag_ld_gpr, 8'd1);
      check_size("mov mem_size", ag_mem_size, sz_dword);
      check_u32("mov disp32", ag_disp32, {24'hff_ffff, d8});
      check_u32("mov eip_next", ag_eip_next, e + 32'(win_len));
      // add [esi+disp32],eax
      d32 = random_bits(32);
      e   = 32'h0040_1100;
      clear_window();
      put_bytes(32'h01, 1);
      put_bytes(32'h86, 1);
      put_bytes(d32, 4);
      issue_single(e);
      check_u8("add uaddr", ag_uaddr, ua_add);
      check_alu("add alu_op", ag_alu_op, alu_add);
      check_seg("add seg1", ag_seg1, ds);
      check_u8("add sr1", ag_sr1, 8'd6);
      check_u8("add sr2", ag_sr2, 8'd0);
      check_u8("add mem_rd", ag_mem_rd, 8'd1);
      check_u8("add mem_wr", ag_mem_wr, 8'd1);
      check_u8("add ld_gpr", ag_ld_gpr, 8'd0);
      check_u32("add disp32", ag_disp32, d32);
      check_u32("add eip_next", ag_eip_next, e + 32'(win_len));
      end_test("mem_operands", start);
   endtask

   task automatic test_prefixed_imm;
      int          start;
      logic [15:0] imm16;
      logic [31:0] e;
      start = errors;
      // 66 64 mov edx,imm16
      imm16 = 16'(random_bits(16));
      e     = 32'h0040_2000;
      clear_window();
      put_bytes(32'hc2c7_6466, 4);
      put_bytes({16'd0, imm16}, 2);
      issue_single(e);
      check_u8("imm uaddr", ag_uaddr, ua_mov_imm);
      check_size("imm sr1_size", ag_sr1_size, sz_word);
      check_size("imm mem_size", ag_mem_size, sz_word);
      check_seg("imm seg1", ag_seg1, fs);
      check_u8("imm sr1", ag_sr1, 8'd2);
      check_u32("imm imm32", ag_imm32, {16'd0, imm16});
      check_u8("imm ld_gpr", ag_ld_gpr, 8'd1);
      check_u8("imm mem_rd", ag_mem_rd, 8'd0);
      check_u8("imm mem_wr", ag_mem_wr, 8'd0);
      check_u32("imm eip_next", ag_eip_next, e + 32'(win_len));
      end_test("prefixed_imm", start);
   endtask

   task automatic test_push_es;
      int          start;
      logic [31:0] e;
      start = errors;
      e     = 32'h0040_3000;
      clear_window();
      put_bytes(32'h06, 1);
      issue_single(e);
      check_u8("push uaddr", ag_uaddr, ua_push_es);
      check_seg("push seg1", ag_seg1, es);
      check_u8("push mem_rd", ag_mem_rd, 8'd0);
      check_u8("push mem_wr", ag_mem_wr, 8'd1);
      check_u8("push gp_exc", ag_gp_exc, 8'd0);
      check_u32("push eip_next", ag_eip_next, e + 32'(win_len));
      end_test("push_es", start);
   endtask

   task automatic test_cmpxchg;
      int          start;
      logic [7:0]  d8;
      logic [31:0] e;
      start = errors;
      // cmpxchg [esp+disp8],edx through a sib byte with a positive disp8
      d8 = {1'b0, 7'(random_bits(7))};
      e  = 32'h0040_4000;
      clear_window();
      put_bytes(32'h2454_b10f, 4);
      put_bytes({24'd0, d8}, 1);
      drive_window(e);
      @(negedge clk);
      check_u8("first uop_stall", uop_stall, 8'd1);
      wait_valid();
      check_u8("first uaddr", ag_uaddr, ua_cmpxchg0);
      check_alu("first alu_op", ag_alu_op, alu_cmp);
      check_seg("first seg1", ag_seg1, ss);
      check_u8("first sr1", ag_sr1, 8'd4);
      check_u8("first sr2", ag_sr2, 8'd2);
      check_u8("first mem_rd", ag_mem_rd, 8'd1);
      check_u8("first mem_wr", ag_mem_wr, 8'd1);
      check_u32("first disp32", ag_disp32, {24'h00_0000, d8});
      check_u32("first eip_next", ag_eip_next, e);
      check_u8("second uop_stall", uop_stall, 8'd0);
      @(posedge clk);
      in_valid <= 1'b0;
      @(negedge clk);
      check_u8("second ag_valid", ag_valid, 8'd1);
      check_u8("second uaddr", ag_uaddr, ua_cmpxchg1);
      check_u8("second mem_wr", ag_mem_wr, 8'd1);
      check_u32("second eip_next", ag_eip_next, e + 32'(win_len));
      end_test("cmpxchg", start);
   endtask

   task automatic test_stall_flush;
      int                 start;
      logic [31:0]        e;
      logic [uaddr_w-1:0] held_uaddr;
      logic [31:0]        held_eip;
      seg_e               held_seg;
      start = errors;
      // cmpxchg [ebx],ecx
      e = 32'h0040_5000;
      clear_window();
      put_bytes(32'h0b_b10f, 3);
      drive_window(e);
      @(posedge clk);
      ag_stall <= 1'b1;
      @(negedge clk);
      check_u8("stalled ag_valid", ag_valid, 8'd1);
      check_u8("stalled uaddr", ag_uaddr, ua_cmpxchg0);
      held_uaddr = ag_uaddr;
      held_eip   = ag_eip_next;
      held_seg   = ag_seg1;
      for (int i = 0; i < 3; i++) begin
         @(posedge clk);
         if (i == 2)
            ag_stall <= 1'b0;
         @(negedge clk);
         check_u8("held ag_valid", ag_valid, 8'd1);
         check_u8("held uaddr", ag_uaddr, held_uaddr);
         check_u32("held eip_next", ag_eip_next, held_eip);
         check_seg("held seg1", ag_seg1, held_seg);
      end
      @(posedge clk);
      in_valid <= 1'b0;
      @(negedge clk);
      check_u8("resumed ag_valid", ag_valid, 8'd1);
      check_u8("resumed uaddr", ag_uaddr, ua_cmpxchg1);
      check_u32("resumed eip_next", ag_eip_next, e + 32'(win_len));
      // flush arrives with a new micro-op pending
      @(posedge clk);
      in_valid <= 1'b1;
      flush    <= 1'b1;
      @(negedge clk);
      check_u8("flush uop_stall", uop_stall, 8'd0);
      @(posedge clk);
      in_valid <= 1'b0;
      flush    <= 1'b0;
      @(negedge clk);
      check_u8("flushed ag_valid", ag_valid, 8'd0);
      end_test("stall_flush", start);
   endtask

   task automatic test_illegal;
      int start;
      start = errors;
      // ud2 is outside the supported set
      clear_window();
      put_bytes(32'h0b0f, 2);
      issue_single(32'h0040_6000);
      check_u8("illegal uaddr", ag_uaddr, ua_illegal);
      check_u8("illegal gp_exc", ag_gp_exc, 8'd1);
      end_test("illegal", start);
   endtask

   initial begin
      int assert_fails;
      reset    = 1'b1;
      in_valid = 1'b0;
      ag_stall = 1'b0;
      flush    = 1'b0;
      ir       = '0;
      eip      = '0;
      repeat (reset_cycles) @(posedge clk);
      reset <= 1'b0;
      test_mem_operands();
      test_prefixed_imm();
      test_push_es();
      test_cmpxchg();
      test_stall_flush();
      test_illegal();
      repeat (2) @(posedge clk);
      assert_fails = dut.u_assertions.fail_count;
      $display("%0d checks, %0d mismatches, %0d assertion failures",
               checks, errors, assert_fails);
      if (errors == 0 && assert_fails == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

// File: x86_decode.f
x86_decode_pkg.sv
instr_field_extract.sv
ucode_rom.sv
decode_stage2.sv
d2_ag_latch.sv
decode_top.sv
decode_assertions.sv
tb_decode.sv

// File: Bender.yml
package:
  name: x86_decode

dependencies: {}

sources:
  - x86_decode_pkg.sv
  - instr_field_extract.sv
  - ucode_rom.sv
  - decode_stage2.sv
  - d2_ag_latch.sv
  - decode_top.sv
  - target: test
    files:
      - decode_assertions.sv
      - tb_decode.sv
